// File: test/pix_patterns.txt
# Header: block width height blanking mid_frame, then width*height pixels in hex, raster order
# Last line of a record: expected highlight_count shadow_count width height
0 8 5 3 0
fff fff 123 456 01f 000 789 abc
000 111 222 333 444 555 666 777
888 999 aaa bbb ccc ddd eee fe0
0f0 1e1 2d2 3c3 4b4 5a5 696 787
fe0 001 876 543 020 fff 210 0ab
2 1 8 5
1 12 3 4 1
005 ffe 3a0 4b1 ff0 010 7c2 8d3 01f 9e4 af5 b06
c17 d28 e39 f4a 05b 16c 27d 38e 49f 5a0 6b1 7c2
8d3 9e4 af5 b06 c17 d28 e39 f4a 05b 16c 27d 38e
1 2 12 3

// File: src.f
design/pix_pkg.sv
design/pix_capture.sv
design/pix_fifo.sv
design/pix_frame_store.sv
design/pix_controller.sv
design/pix_top.sv
test/pix_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the pix_top testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module pix_tb -Mdir obj_dir -o pix_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/pix_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "^Verification passed$"; then
    exit 0
fi
exit 1

// File: test/pix_tb.sv
module pix_tb;
    import pix_pkg::*;

    localparam int CAPTURE_LIMIT = 2000;
    localparam int READY_LIMIT   = 200;

    logic                   clk;
    logic                   fifoIn_rst;
    logic [1:0]             cmd;
    logic                   cmd_block;
    logic [11:0]            pix_d;
    logic                   pix_fv;
    logic                   pix_lv;
    logic                   readout_trigger;
    logic                   readout_ready;
    logic [15:0]            readout_data;
    logic                   capture_done;
    logic                   readout_started;
    logic [WIDTH_BITS-1:0]  capture_width;
    logic [HEIGHT_BITS-1:0] capture_height;
    logic [COUNT_BITS-1:0]  highlight_count;
    logic [COUNT_BITS-1:0]  shadow_count;

    logic [31:0] lfsr;
    logic [11:0] frame_pix [$];
    // Expected store contents, keyed by block * 256 + word index
    logic [15:0] stored_words [int];
    int          stored_len [int];

    pix_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ====================
    // Helpers
    // ====================
    task automatic tick;
        @(posedge clk);
        #2;
    endtask

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int actual, input int expected);
        assert (actual == expected) else fail_run($sformatf(
            "Error at time %0t: %s is %0h, expected %0h", $time, name, actual, expected));
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic take_bit(output logic b);
        b = lfsr[0];
        lfsr = lfsr_step(lfsr);
    endtask

    task automatic send_command(input logic [1:0] code, input logic blk);
        cmd       = code;
        cmd_block = blk;
        tick;
        cmd = CMD_NONE;
    endtask

    // One sensor frame; a decoy frame is all highlights and may carry a capture command
    task automatic send_frame(input bit decoy, input int w, input int h, input int blank,
                              input int cmd_line, input logic blk);
        pix_fv = 1'b1;
        repeat (blank) tick;
        for (int r = 0; r < h; r++) begin
            if (r == cmd_line) begin
                send_command(CMD_CAPTURE, blk);
            end
            for (int c = 0; c < w; c++) begin
                pix_lv = 1'b1;
                pix_d  = decoy ? 12'hfff : frame_pix[r*w + c];
                tick;
            end
            pix_lv = 1'b0;
            pix_d  = '0;
            repeat (blank) tick;
        end
        pix_fv = 1'b0;
    endtask

    task automatic wait_capture_done;
        int n;
        n = 0;
        while (!capture_done && n < CAPTURE_LIMIT) begin
            tick;
            n++;
        end
        assert (capture_done) else fail_run("capture_done never pulsed after the frame ended");
    endtask

    task automatic wait_readout_ready;
        int n;
        n = 0;
        while (!readout_ready && n < READY_LIMIT) begin
            tick;
            n++;
        end
        assert (readout_ready) else fail_run("readout_ready stayed low while words were due");
    endtask

    // Start a readout and pop count words with random gaps between pops
    task automatic run_readout(input logic blk, input int count, input bit check_idle);
        int   n;
        logic b;
        send_command(CMD_READOUT, blk);
        check_value("readout_started", int'(readout_started), 0);
        tick;
        check_value("readout_started", int'(readout_started), 1);
        for (int i = 0; i < count; i++) begin
            wait_readout_ready();
            check_value("readout_data", int'(readout_data),
                        int'(stored_words[int'(blk) * 256 + i]));
            readout_trigger = 1'b1;
            tick;
            readout_trigger = 1'b0;
            n = 0;
            take_bit(b);
            while (b && n < 3) begin
                tick;
                n++;
                take_bit(b);
            end
        end
        if (check_idle) begin
            repeat (50) begin
                check_value("readout_ready", int'(readout_ready), 0);
                tick;
            end
        end
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        int    fd;
        int    rc;
        int    blk;
        int    w;
        int    h;
        int    blank;
        int    mid;
        int    val;
        int    e_hl;
        int    e_sh;
        int    e_w;
        int    e_h;
        string line;

        fifoIn_rst      = 1'b0;
        cmd             = CMD_NONE;
        cmd_block       = 1'b0;
        pix_d           = '0;
        pix_fv          = 1'b0;
        pix_lv          = 1'b0;
        readout_trigger = 1'b0;
        lfsr            = 32'h3a577dab;
        repeat (4) tick;
        fifoIn_rst = 1'b1;
        check_value("capture_done", int'(capture_done), 0);
        check_value("readout_started", int'(readout_started), 0);
        check_value("readout_ready", int'(readout_ready), 0);

        fd = $fopen("test/pix_patterns.txt", "r");
        assert (fd != 0) else fail_run("could not open test/pix_patterns.txt");
        rc = $fgets(line, fd);
        rc = $fgets(line, fd);

        // Frame A goes in with the sensor idle, frame B is armed mid-frame
        for (int f = 0; f < 2; f++) begin
            rc = $fscanf(fd, "%d %d %d %d %d", blk, w, h, blank, mid);
            assert (rc == 5) else fail_run("frame header missing in the pattern file");
            frame_pix.delete();
            for (int i = 0; i < w * h; i++) begin
                rc = $fscanf(fd, "%h", val);
                assert (rc == 1) else fail_run("pixel value missing in the pattern file");
                frame_pix.push_back(12'(val));
                stored_words[blk * 256 + i] = {4'h0, 12'(val)};
            end
            stored_len[blk] = w * h;
            rc = $fscanf(fd, "%d %d %d %d", e_hl, e_sh, e_w, e_h);
            assert (rc == 4) else fail_run("expected values missing in the pattern file");

            if (mid != 0) begin
                send_frame(1'b1, 16, 6, blank, 2, 1'(blk));
            end else begin
                send_command(CMD_CAPTURE, 1'(blk));
            end
            repeat (blank + 4) tick;
            send_frame(1'b0, w, h, blank, -1, 1'(blk));
            wait_capture_done();
            check_value("capture_width", int'(capture_width), e_w);
            check_value("capture_height", int'(capture_height), e_h);
            check_value("highlight_count", int'(highlight_count), e_hl);
            check_value("shadow_count", int'(shadow_count), e_sh);
            repeat (blank) tick;
        end
        $fclose(fd);

        run_readout(1'b0, stored_len[0], 1'b1);
        run_readout(1'b1, stored_len[1], 1'b1);

        // Abort a readout of block 0 part way through
        run_readout(1'b0, 3, 1'b0);
        run_readout(1'b1, stored_len[1], 1'b1);

        $display("Verification passed");
        $finish;
    end

endmodule

// File: design/pix_top.sv
module pix_top (
    input  logic                            clk,
    input  logic                            fifoIn_rst,
    input  logic [1:0]                      cmd,
    input  logic                            cmd_block,
    input  logic [11:0]                     pix_d,
    input  logic                            pix_fv,
    input  logic                            pix_lv,
    input  logic                            readout_trigger,
    output logic                            readout_ready,
    output logic [15:0]                     readout_data,
    output logic                            capture_done,
    output logic                            readout_started,
    output logic [pix_pkg::WIDTH_BITS-1:0]  capture_width,
    output logic [pix_pkg::HEIGHT_BITS-1:0] capture_height,
    output logic [pix_pkg::COUNT_BITS-1:0]  highlight_count,
    output logic [pix_pkg::COUNT_BITS-1:0]  shadow_count
);
    import pix_pkg::*;

    // Capture stage to input FIFO
    logic        cap_arm;
    logic        cap_started;
    logic        cap_done;
    logic        cap_trigger;
    pix_word_u   cap_data;
    logic        in_w_ready;

    // Input FIFO to controller
    logic        in_ready;
    logic        in_trigger;
    logic [15:0] in_data;

    // Controller to frame store
    logic        wr_start;
    logic        wr_block;
    logic        wr_trigger;
    logic [15:0] wr_data;
    logic        rd_start;
    logic        rd_block;
    logic        out_flush;

    // Frame store to output FIFO
    logic        rd_ready;
    logic        rd_trigger;
    logic [15:0] rd_data;

    pix_capture u_capture (
        .clk,
        .fifoIn_rst,
        .pix_d,
        .pix_fv,
        .pix_lv,
        .arm             (cap_arm),
        .fifo_ready      (in_w_ready),
        .started         (cap_started),
        .done            (cap_done),
        .fifo_trigger    (cap_trigger),
        .fifo_data       (cap_data),
        .image_width     (capture_width),
        .image_height    (capture_height),
        .highlight_count,
        .shadow_count
    );

    pix_fifo u_fifo_in (
        .clk,
        .fifoIn_rst,
        .flush     (1'b0),
        .w_trigger (cap_trigger),
        .w_data    (cap_data),
        .w_ready   (in_w_ready),
        .r_trigger (in_trigger),
        .r_ready   (in_ready),
        .r_data    (in_data)
    );

    pix_controller u_controller (.*);

    pix_frame_store u_frame_store (.*);

    // The store advances only while the output FIFO has room
    pix_fifo u_fifo_out (
        .clk,
        .fifoIn_rst,
        .flush     (out_flush),
        .w_trigger (rd_ready),
        .w_data    (rd_data),
        .w_ready   (rd_trigger),
        .r_trigger (readout_trigger),
        .r_ready   (readout_ready),
        .r_data    (readout_data)
    );

endmodule

// File: design/pix_controller.sv
module pix_controller (
    input  logic        clk,
    input  logic        fifoIn_rst,
    input  logic [1:0]  cmd,
    input  logic        cmd_block,
    input  logic        cap_started,
    input  logic        cap_done,
    input  logic        in_ready,
    input  logic [15:0] in_data,
    output logic        cap_arm,
    output logic        in_trigger,
    output logic        wr_start,
    output logic        wr_block,
    output logic        wr_trigger,
    output logic [15:0] wr_data,
    output logic        rd_start,
    output logic        rd_block,
    output logic        out_flush,
    output logic        capture_done,
    output logic        readout_started
);
    import pix_pkg::*;

    logic [2:0] state;
    logic       block_q;

    // ====================
    // Strobes to the pipeline
    // ====================
    assign cap_arm   = (state == CTL_CAP_START);
    assign wr_start  = (state == CTL_CAP_START);
    assign wr_block  = block_q;
    assign rd_start  = (state == CTL_RD_START);
    assign out_flush = (state == CTL_RD_START);
    assign rd_block  = block_q;

    // Input FIFO drains one word per cycle
    // outside the copy state the words are leftovers and get dropped
    assign in_trigger = in_ready;
    assign wr_trigger = in_ready && (state == CTL_CAP_COPY);
    assign wr_data    = in_data;

    // ====================
    // Command FSM
    // ====================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            state           <= CTL_IDLE;
            block_q         <= 1'b0;
            capture_done    <= 1'b0;
            readout_started <= 1'b0;
        end else begin
            capture_done    <= 1'b0;
            readout_started <= 1'b0;

            case (state)
                CTL_CAP_START: begin
                    state <= CTL_CAP_WAIT;
                end
                CTL_CAP_WAIT: begin
                    if (cap_started) begin
                        state <= CTL_CAP_COPY;
                    end
                end
                // Finished once the frame ended and every pixel is stored
                CTL_CAP_COPY: begin
                    if (cap_done && !in_ready) begin
                        capture_done <= 1'b1;
                        state        <= CTL_IDLE;
                    end
                end
                CTL_RD_START: begin
                    readout_started <= 1'b1;
                    state           <= CTL_IDLE;
                end
                default: begin
                end
            endcase

            // A new command aborts whatever is running
            if (cmd != CMD_NONE) begin
                block_q <= cmd_block;
                case (cmd)
                    CMD_CAPTURE: state <= CTL_CAP_START;
                    CMD_READOUT: state <= CTL_RD_START;
                    default:     state <= CTL_IDLE;
                endcase
            end
        end
    end

endmodule

// File: design/pix_frame_store.sv
module pix_frame_store (
    input  logic        clk,
    input  logic        fifoIn_rst,
    input  logic        wr_start,
    input  logic        wr_block,
    input  logic        wr_trigger,
    input  logic [15:0] wr_data,
    input  logic        rd_start,
    input  logic        rd_block,
    input  logic        rd_trigger,
    output logic        rd_ready,
    output logic [15:0] rd_data
);
    import pix_pkg::*;

    logic [15:0]          mem [2*BLOCK_DEPTH];
    logic                 wr_blk_q;
    logic [ADDR_BITS-1:0] wr_addr;
    logic [ADDR_BITS:0]   len [2];
    logic                 rd_blk_q;
    logic [ADDR_BITS-1:0] rd_addr;
    logic [ADDR_BITS:0]   rd_left;
    logic                 wr_en;
    logic                 fetch;

    // A full block ignores further words
    assign wr_en = wr_trigger && (len[wr_blk_q] != (ADDR_BITS+1)'(BLOCK_DEPTH));

    // Refill the output register when it is empty or being taken
    assign fetch = !rd_start && (rd_left != '0) && (!rd_ready || rd_trigger);

    // ====================
    // Memory array
    // ====================
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[{wr_blk_q, wr_addr}] <= wr_data;
        end
        if (fetch) begin
            rd_data <= mem[{rd_blk_q, rd_addr}];
        end
    end

    // ====================
    // Write side
    // ====================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            wr_blk_q <= 1'b0;
            wr_addr  <= '0;
            len[0]   <= '0;
            len[1]   <= '0;
        end else if (wr_start) begin
            wr_blk_q      <= wr_block;
            wr_addr       <= '0;
            len[wr_block] <= '0;
        end else if (wr_en) begin
            wr_addr       <= wr_addr + 1'b1;
            len[wr_blk_q] <= len[wr_blk_q] + 1'b1;
        end
    end

    // ====================
    // Read side
    // ====================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            rd_blk_q <= 1'b0;
            rd_addr  <= '0;
            rd_left  <= '0;
            rd_ready <= 1'b0;
        end else if (rd_start) begin
            rd_blk_q <= rd_block;
            rd_addr  <= '0;
            rd_left  <= len[rd_block];
            rd_ready <= 1'b0;
        end else if (fetch) begin
            rd_addr  <= rd_addr + 1'b1;
            rd_left  <= rd_left - 1'b1;
            rd_ready <= 1'b1;
        end else if (rd_trigger) begin
            rd_ready <= 1'b0;
        end
    end

    ap_start_alone: assert property (@(posedge clk) disable iff (!fifoIn_rst)
        !(wr_trigger && wr_start))
        else $error("pix_frame_store: write in the same cycle as wr_start");

endmodule

// File: design/pix_fifo.sv
module pix_fifo #(
    parameter int DEPTH_LOG2 = 4
) (
    input  logic        clk,
    input  logic        fifoIn_rst,
    input  logic        flush,
    input  logic        w_trigger,
    input  logic [15:0] w_data,
    output logic        w_ready,
    input  logic        r_trigger,
    output logic        r_ready,
    output logic [15:0] r_data
);
    localparam int DEPTH = 1 << DEPTH_LOG2;

    logic [15:0]           mem [DEPTH];
    logic [DEPTH_LOG2-1:0] wptr;
    logic [DEPTH_LOG2-1:0] rptr;
    logic [DEPTH_LOG2:0]   count;
    logic                  do_write;
    logic                  do_read;

    assign w_ready  = (count != (DEPTH_LOG2+1)'(DEPTH));
    assign r_ready  = (count != '0);
    assign do_write = w_trigger && w_ready;
    assign do_read  = r_trigger && r_ready;

    // Show-ahead read port
    assign r_data = mem[rptr];

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wptr] <= w_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!fifoIn_rst || flush) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                wptr <= wptr + 1'b1;
            end
            if (do_read) begin
                rptr <= rptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    ap_no_pop_empty: assert property (@(posedge clk) disable iff (!fifoIn_rst)
        r_trigger |-> r_ready)
        else $error("pix_fifo: pop while empty");

    ap_count_bound: assert property (@(posedge clk) disable iff (!fifoIn_rst)
        count <= (DEPTH_LOG2+1)'(DEPTH))
        else $error("pix_fifo: occupancy above depth");

endmodule

// File: design/pix_capture.sv
module pix_capture (
    input  logic                            clk,
    input  logic                            fifoIn_rst,
    input  logic [11:0]                     pix_d,
    input  logic                            pix_fv,
    input  logic                            pix_lv,
    input  logic                            arm,
    input  logic                            fifo_ready,
    output logic                            started,
    output logic                            done,
    output logic                            fifo_trigger,
    output pix_pkg::pix_word_u              fifo_data,
    output logic [pix_pkg::WIDTH_BITS-1:0]  image_width,
    output logic [pix_pkg::HEIGHT_BITS-1:0] image_height,
    output logic [pix_pkg::COUNT_BITS-1:0]  highlight_count,
    output logic [pix_pkg::COUNT_BITS-1:0]  shadow_count
);
    import pix_pkg::*;

    logic [11:0] d_q;
    logic        fv_q;
    logic        lv_q;
    logic        lv_prev;
    logic [2:0]  state;
    logic [1:0]  col;
    logic [1:0]  row;
    logic        writing;
    logic        pix_take;
    logic        on_grid;

    // ====================
    // Sensor input registers
    // ====================
    always_ff @(posedge clk) begin
        d_q <= pix_d;
    end

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            fv_q    <= 1'b0;
            lv_q    <= 1'b0;
            lv_prev <= 1'b0;
        end else begin
            fv_q    <= pix_fv;
            lv_q    <= pix_lv;
            lv_prev <= lv_q;
        end
    end

    // The first frame-valid cycle already counts as part of the frame
    assign writing  = fv_q && (state == CAP_WRITE || state == CAP_WAIT_HIGH);
    assign pix_take = writing && lv_q;
    assign on_grid  = (col == 2'd0) && (row == 2'd0);

    assign fifo_trigger   = pix_take && fifo_ready;
    assign fifo_data.raw  = {4'h0, d_q};

    // ====================
    // Capture FSM and statistics
    // ====================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            state           <= CAP_IDLE;
            started         <= 1'b0;
            done            <= 1'b0;
            col             <= 2'd0;
            row             <= 2'd0;
            image_width     <= '0;
            image_height    <= '0;
            highlight_count <= '0;
            shadow_count    <= '0;
        end else begin
            started <= 1'b0;

            // Grid position, modulo 4
            col <= lv_q ? col + 2'd1 : 2'd0;
            if (!fv_q) begin
                row <= 2'd0;
            end else if (lv_prev && !lv_q) begin
                row <= row + 2'd1;
            end

            if (pix_take) begin
                if (!lv_prev) begin
                    image_width  <= WIDTH_BITS'(1);
                    image_height <= image_height + 1'b1;
                end else begin
                    image_width <= image_width + 1'b1;
                end
                if (on_grid && fifo_data.sample.top == 7'h7f) begin
                    highlight_count <= highlight_count + 1'b1;
                end
                if (on_grid && fifo_data.sample.top == 7'h00) begin
                    shadow_count <= shadow_count + 1'b1;
                end
            end

            case (state)
                CAP_CLEAR: begin
                    done            <= 1'b0;
                    image_width     <= '0;
                    image_height    <= '0;
                    highlight_count <= '0;
                    shadow_count    <= '0;
                    started         <= 1'b1;
                    state           <= CAP_WAIT_LOW;
                end
                // Skip the rest of a frame already in progress
                CAP_WAIT_LOW: begin
                    if (!fv_q) begin
                        state <= CAP_WAIT_HIGH;
                    end
                end
                CAP_WAIT_HIGH: begin
                    if (fv_q) begin
                        state <= CAP_WRITE;
                    end
                end
                CAP_WRITE: begin
                    if (!fv_q) begin
                        done  <= 1'b1;
                        state <= CAP_IDLE;
                    end
                end
                default: begin
                end
            endcase

            if (arm) begin
                state <= CAP_CLEAR;
            end
        end
    end

    ap_no_write_full: assert property (@(posedge clk) disable iff (!fifoIn_rst)
        pix_take |-> fifo_ready)
        else $error("pix_capture: pixel dropped with the input FIFO full");

endmodule

// File: design/pix_pkg.sv
package pix_pkg;

    // ====================
    // Command port
    // ====================
    localparam logic [1:0] CMD_NONE    = 2'b00;
    localparam logic [1:0] CMD_CAPTURE = 2'b01;
    localparam logic [1:0] CMD_READOUT = 2'b10;

    // ====================
    // Image and store sizes
    // ====================
    localparam int IMAGE_WIDTH_MAX  = 16;
    localparam int IMAGE_HEIGHT_MAX = 8;
    localparam int BLOCK_DEPTH      = IMAGE_WIDTH_MAX * IMAGE_HEIGHT_MAX;
    localparam int WIDTH_BITS       = 5;
    localparam int HEIGHT_BITS      = 4;
    localparam int ADDR_BITS        = 7;
    localparam int COUNT_BITS       = 8;

    // Capture stage FSM
    localparam logic [2:0] CAP_IDLE      = 3'd0;
    localparam logic [2:0] CAP_CLEAR     = 3'd1;
    localparam logic [2:0] CAP_WAIT_LOW  = 3'd2;
    localparam logic [2:0] CAP_WAIT_HIGH = 3'd3;
    localparam logic [2:0] CAP_WRITE     = 3'd4;

    // Controller FSM
    localparam logic [2:0] CTL_IDLE      = 3'd0;
    localparam logic [2:0] CTL_CAP_START = 3'd1;
    localparam logic [2:0] CTL_CAP_WAIT  = 3'd2;
    localparam logic [2:0] CTL_CAP_COPY  = 3'd3;
    localparam logic [2:0] CTL_RD_START  = 3'd4;

    // One stored word, seen either as raw data or split for the
    // highlight/shadow test (top 7 bits of the 12-bit pixel)
    typedef union packed {
        logic [15:0] raw;
        struct packed {
            logic [3:0] pad;
            logic [6:0] top;
            logic [4:0] low;
        } sample;
    } pix_word_u;

endpackage
